//--- rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// Datapath widths
	localparam int DATA_W = 16;
	localparam int ACC_W = 32;

	// Layer geometry
	localparam int NUM_FILTERS = 4;
	localparam int CHIN = 8;
	localparam int CH_IDX_W = 3;
	localparam int OUT_PIXELS = 16;
	localparam int PIX_CNT_W = 4;

	// Fixed-point handling of the accumulated sums
	localparam int FRAC_SHIFT = 14;
	localparam int SAT_LIMIT = 32767;

	// Kernel weights are small integers scaled up by this shift
	localparam int W_SHIFT = 8;

	// Bias of filter f is f * BIAS_STEP - BIAS_BASE
	localparam int BIAS_STEP = 4096;
	localparam int BIAS_BASE = 6000;

	// Input FIFO between streamer and core
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;
	localparam int FIFO_CNT_W = 3;

	// One input feature value with its channel tag
	typedef struct packed {
		logic signed [DATA_W-1:0] value;
		logic [CH_IDX_W-1:0] ch_idx;
		logic last;
	} ifm_beat_t;

	// One output pixel with filter 0 in the low bits
	typedef struct packed {
		logic [NUM_FILTERS-1:0][DATA_W-1:0] ofm;
	} ofm_vec_t;

	typedef struct packed {
		logic [NUM_FILTERS-1:0][DATA_W-1:0] weight;
	} weight_vec_t;

	typedef struct packed {
		logic [NUM_FILTERS-1:0][ACC_W-1:0] bias;
	} bias_vec_t;

endpackage

`default_nettype wire

//--- rtl/kernel_rom.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_rom (
	input  logic [conv_pkg::CH_IDX_W-1:0] ch_idx,
	output conv_pkg::weight_vec_t          weights,
	output conv_pkg::bias_vec_t            biases
);

	import conv_pkg::*;

	// Unscaled coefficients for filters 0 to 3 of the selected channel
	logic signed [DATA_W-1:0] coef [NUM_FILTERS];

	// Entries follow ((f * 8 + c) * 37 mod 97) - 48
	always_comb begin
		case (ch_idx)
			3'd0: begin
				coef = '{-48, -43, -38, -33};
			end
			3'd1: begin
				coef = '{-11, -6, -1, 4};
			end
			3'd2: begin
				coef = '{26, 31, 36, 41};
			end
			3'd3: begin
				coef = '{-34, -29, -24, -19};
			end
			3'd4: begin
				coef = '{3, 8, 13, 18};
			end
			3'd5: begin
				coef = '{40, 45, -47, -42};
			end
			3'd6: begin
				coef = '{-20, -15, -10, -5};
			end
			3'd7: begin
				coef = '{17, 22, 27, 32};
			end
			default: begin
				coef = '{default: '0};
			end
		endcase
	end

	// Scale each coefficient into the weight format and build the bias set
	always_comb begin
		for (int f = 0; f < NUM_FILTERS; f++) begin
			weights.weight[f] = coef[f] <<< W_SHIFT;
			biases.bias[f] = ACC_W'(f * BIAS_STEP - BIAS_BASE);
		end
	end

endmodule

`default_nettype wire

//--- rtl/ifm_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module ifm_streamer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic [conv_pkg::DATA_W-1:0] in_data,
	output logic                      in_ready,
	output logic                      beat_valid,
	output conv_pkg::ifm_beat_t       beat,
	input  logic                      beat_ready
);

	import conv_pkg::*;

	logic [CH_IDX_W-1:0] ch_cnt;
	logic                valid_q;
	ifm_beat_t           beat_q;
	logic                in_fire;

	// The output register can take a new value when it drains this cycle
	assign in_ready = !valid_q || beat_ready;
	assign in_fire = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			ch_cnt <= '0;
		end else if (in_fire) begin
			valid_q <= 1'b1;
			if (ch_cnt == CH_IDX_W'(CHIN - 1)) begin
				ch_cnt <= '0;
			end else begin
				ch_cnt <= ch_cnt + 1'b1;
			end
		end else if (beat_ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			beat_q.value <= $signed(in_data);
			beat_q.ch_idx <= ch_cnt;
			beat_q.last <= (ch_cnt == CH_IDX_W'(CHIN - 1));
		end
	end

	assign beat_valid = valid_q;
	assign beat = beat_q;

	// A stalled beat must not change before the FIFO takes it
	beat_hold_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		beat_valid && !beat_ready |=> beat_valid && $stable(beat)
	);

endmodule

`default_nettype wire

//--- rtl/ifm_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ifm_fifo (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_valid,
	output logic                wr_ready,
	input  conv_pkg::ifm_beat_t wr_beat,
	output logic                rd_valid,
	input  logic                rd_ready,
	output conv_pkg::ifm_beat_t rd_beat
);

	import conv_pkg::*;

	ifm_beat_t             mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  wr_fire;
	logic                  rd_fire;

	assign wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
	assign rd_valid = (count != '0);
	assign wr_fire = wr_valid && wr_ready;
	assign rd_fire = rd_valid && rd_ready;

	assign rd_beat = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_beat;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_fire, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	count_range_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		count <= FIFO_CNT_W'(FIFO_DEPTH)
	);

	// An empty FIFO with no write has nothing to offer on the next cycle
	no_read_empty_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		(count == '0) && !wr_fire |=> !rd_valid
	);

	// Occupancy and pointer distance agree
	ptr_count_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		FIFO_PTR_W'(count) == FIFO_PTR_W'(wr_ptr - rd_ptr)
	);

endmodule

`default_nettype wire

//--- rtl/pointwise_core.sv
`timescale 1ns/1ps
`default_nettype none

module pointwise_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                beat_valid,
	output logic                beat_ready,
	input  conv_pkg::ifm_beat_t beat,
	output logic                out_valid,
	input  logic                out_ready,
	output conv_pkg::ofm_vec_t  out_data,
	output logic                layer_done
);

	import conv_pkg::*;

	weight_vec_t               weights;
	bias_vec_t                 biases;
	logic signed [ACC_W-1:0]   acc [NUM_FILTERS];
	logic signed [ACC_W-1:0]   prod [NUM_FILTERS];
	logic signed [ACC_W-1:0]   total [NUM_FILTERS];
	ofm_vec_t                  result_q;
	logic                      valid_q;
	logic                      done_q;
	logic [PIX_CNT_W-1:0]      pix_cnt;
	logic                      beat_fire;
	logic                      out_fire;

	// Negative sums clip to zero, large ones saturate
	function automatic logic [DATA_W-1:0] requant(input logic signed [ACC_W-1:0] sum);
		logic signed [ACC_W-1:0] shifted;
		shifted = sum >>> FRAC_SHIFT;
		if (sum < 0) begin
			return '0;
		end else if (shifted > SAT_LIMIT) begin
			return DATA_W'(SAT_LIMIT);
		end else begin
			return shifted[DATA_W-1:0];
		end
	endfunction

	kernel_rom kernel_rom_inst (
		.ch_idx  (beat.ch_idx),
		.weights (weights),
		.biases  (biases)
	);

	// Input stalls only while a finished pixel waits to be taken
	assign beat_ready = !valid_q || out_ready;
	assign beat_fire = beat_valid && beat_ready;
	assign out_fire = valid_q && out_ready;

	always_comb begin
		for (int f = 0; f < NUM_FILTERS; f++) begin
			prod[f] = $signed(beat.value) * $signed(weights.weight[f]);
			total[f] = acc[f] + prod[f] + $signed(biases.bias[f]);
		end
	end

	// The accumulators restart at the last channel so the next pixel
	// can proceed while the result register is still occupied
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int f = 0; f < NUM_FILTERS; f++) begin
				acc[f] <= '0;
			end
		end else if (beat_fire) begin
			for (int f = 0; f < NUM_FILTERS; f++) begin
				if (beat.last) begin
					acc[f] <= '0;
				end else begin
					acc[f] <= acc[f] + prod[f];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat_fire && beat.last) begin
			for (int f = 0; f < NUM_FILTERS; f++) begin
				result_q.ofm[f] <= requant(total[f]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (beat_fire && beat.last) begin
			valid_q <= 1'b1;
		end else if (out_ready) begin
			valid_q <= 1'b0;
		end
	end

	// Count transferred pixels once, then hold the done flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt <= '0;
			done_q <= 1'b0;
		end else if (out_fire && !done_q) begin
			pix_cnt <= pix_cnt + 1'b1;
			if (pix_cnt == PIX_CNT_W'(OUT_PIXELS - 1)) begin
				done_q <= 1'b1;
			end
		end
	end

	assign out_valid = valid_q;
	assign out_data = result_q;
	assign layer_done = done_q;

	out_hold_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	);

	// The streamer marks exactly the top channel as the last one
	last_tag_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		beat_fire |-> (beat.last == (beat.ch_idx == CH_IDX_W'(CHIN - 1)))
	);

endmodule

`default_nettype wire

//--- rtl/squeeze_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_layer_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid,
	input  logic [conv_pkg::DATA_W-1:0] in_data,
	output logic                        in_ready,
	output logic                        out_valid,
	input  logic                        out_ready,
	output conv_pkg::ofm_vec_t          out_data,
	output logic                        layer_done
);

	import conv_pkg::*;

	// Streamer to FIFO
	logic      str_valid;
	logic      str_ready;
	ifm_beat_t str_beat;

	// FIFO to core
	logic      core_valid;
	logic      core_ready;
	ifm_beat_t core_beat;

	ifm_streamer ifm_streamer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.beat_valid (str_valid),
		.beat       (str_beat),
		.beat_ready (str_ready)
	);

	ifm_fifo ifm_fifo_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_valid (str_valid),
		.wr_ready (str_ready),
		.wr_beat  (str_beat),
		.rd_valid (core_valid),
		.rd_ready (core_ready),
		.rd_beat  (core_beat)
	);

	pointwise_core pointwise_core_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat_valid (core_valid),
		.beat_ready (core_ready),
		.beat       (core_beat),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.layer_done (layer_done)
	);

endmodule

`default_nettype wire

//--- verification/squeeze_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_layer_tb;

	import conv_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'hb6d0_7b7e;
	localparam int TOTAL_PIXELS = 22;
	localparam int TOTAL_BEATS = TOTAL_PIXELS * CHIN;
	localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 1000;
	localparam int HOLD_CYCLES = 30;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [DATA_W-1:0] in_data;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	ofm_vec_t out_data;
	logic layer_done;

	logic [31:0] stim_lfsr = LFSR_SEED;
	logic [31:0] stall_lfsr = LFSR_SEED;
	logic signed [DATA_W-1:0] pix [CHIN];
	logic [DATA_W-1:0] in_q [$];
	int stall_mode = 0;
	int out_count = 0;
	int value_errs = 0;
	int other_errs = 0;
	bit ready_dropped = 0;
	bit ready_recovered = 0;
	bit seen_zero = 0;
	bit seen_sat = 0;
	bit seen_plain = 0;

	squeeze_layer_top squeeze_layer_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.layer_done (layer_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_next(state);
			bits = {bits[30:0], state[0]};
		end
	endtask

	function automatic int kernel_coef(input int f, input int c);
		return ((f * 8 + c) * 37) % 97 - 48;
	endfunction

	function automatic logic [DATA_W-1:0] requant_ref(input logic signed [ACC_W-1:0] sum);
		logic signed [ACC_W-1:0] q;
		if (sum < 0) begin
			return '0;
		end
		q = sum / (1 << FRAC_SHIFT);
		if (q > SAT_LIMIT) begin
			return DATA_W'(SAT_LIMIT);
		end
		return q[DATA_W-1:0];
	endfunction

	// Expected output vector of one pixel from its eight channel values
	function automatic ofm_vec_t ref_pixel(input logic signed [DATA_W-1:0] px [CHIN]);
		ofm_vec_t res;
		logic signed [ACC_W-1:0] sum;
		int w;
		for (int f = 0; f < NUM_FILTERS; f++) begin
			sum = ACC_W'(f * BIAS_STEP - BIAS_BASE);
			for (int c = 0; c < CHIN; c++) begin
				w = kernel_coef(f, c) * (1 << W_SHIFT);
				sum = sum + px[c] * w;
			end
			res.ofm[f] = requant_ref(sum);
		end
		return res;
	endfunction

	task automatic check_ofm(input ofm_vec_t exp, input ofm_vec_t act);
		if (act !== exp) begin
			value_errs++;
			$display("[ERROR] out_data pixel %0d expected %h actual %h", out_count, exp, act);
		end
	endtask

	task automatic check_done(input logic exp, input logic act);
		if (act !== exp) begin
			value_errs++;
			$display("[ERROR] layer_done expected %h actual %h", exp, act);
		end
	endtask

	task automatic note_outcomes(input ofm_vec_t vec);
		for (int f = 0; f < NUM_FILTERS; f++) begin
			if (vec.ofm[f] == '0) begin
				seen_zero = 1'b1;
			end else if (vec.ofm[f] == DATA_W'(SAT_LIMIT)) begin
				seen_sat = 1'b1;
			end else begin
				seen_plain = 1'b1;
			end
		end
	endtask

	task automatic fill_const(input int v);
		for (int c = 0; c < CHIN; c++) begin
			pix[c] = DATA_W'(v);
		end
	endtask

	// Small signed values keep every sum well inside the accumulator
	task automatic fill_random();
		logic [31:0] bits;
		for (int c = 0; c < CHIN; c++) begin
			draw_bits(stim_lfsr, 12, bits);
			pix[c] = {{(DATA_W-12){bits[11]}}, bits[11:0]};
		end
	endtask

	// Each value follows the sign of the filter 0 weight, so mag steers filter 0
	task automatic fill_chosen(input int mag);
		for (int c = 0; c < CHIN; c++) begin
			pix[c] = (kernel_coef(0, c) >= 0) ? DATA_W'(mag) : DATA_W'(-mag);
		end
	endtask

	task automatic send_value(input logic [DATA_W-1:0] v, input bit gaps);
		logic [31:0] bits;
		int idle;
		idle = 0;
		if (gaps) begin
			draw_bits(stim_lfsr, 2, bits);
			idle = int'(bits[1:0]);
		end
		repeat (idle) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
		@(posedge clk);
		in_valid <= 1'b1;
		in_data <= v;
		// The transfer happens on the next rising edge once in_ready is seen high
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
	endtask

	task automatic send_pixel(input bit gaps);
		for (int c = 0; c < CHIN; c++) begin
			send_value(pix[c], gaps);
		end
	endtask

	// Mode 1 starts with a long hold so the input path backs up, then stalls at random
	initial begin : ready_driver
		logic [31:0] bits;
		int held;
		out_ready = 1'b0;
		held = 0;
		forever begin
			@(posedge clk);
			if (stall_mode == 0) begin
				out_ready <= 1'b1;
				held = 0;
			end else if (held < HOLD_CYCLES) begin
				out_ready <= 1'b0;
				held++;
			end else begin
				draw_bits(stall_lfsr, 2, bits);
				out_ready <= (bits[1:0] == 2'b00);
			end
		end
	end

	initial begin : monitor
		logic signed [DATA_W-1:0] got [CHIN];
		ofm_vec_t exp;
		ofm_vec_t held;
		logic stalled;
		stalled = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				stalled = 1'b0;
				continue;
			end
			if (in_valid && in_ready) begin
				in_q.push_back(in_data);
			end
			if (!in_ready) begin
				ready_dropped = 1'b1;
			end else if (ready_dropped) begin
				ready_recovered = 1'b1;
			end
			check_done(out_count >= OUT_PIXELS, layer_done);
			if (stalled) begin
				if (!out_valid) begin
					other_errs++;
					$display("out_valid fell while the output was stalled");
				end else begin
					check_ofm(held, out_data);
				end
			end
			stalled = out_valid && !out_ready;
			held = out_data;
			if (out_valid && out_ready) begin
				if (in_q.size() < CHIN) begin
					other_errs++;
					$display("an output vector came out before its pixel was fully sent");
				end else begin
					for (int c = 0; c < CHIN; c++) begin
						got[c] = in_q.pop_front();
					end
					exp = ref_pixel(got);
					note_outcomes(out_data);
					check_ofm(exp, out_data);
				end
				out_count++;
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("simulation timed out after %0d cycles with %0d outputs",
			TIMEOUT_CYCLES, out_count);
		$display("tests failed");
		$finish;
	end

	initial begin : main_seq
		in_valid = 1'b0;
		in_data = '0;
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// One plain pixel of constant values
		fill_const(256);
		send_pixel(1'b0);

		repeat (8) begin
			fill_random();
			send_pixel(1'b1);
		end

		stall_mode = 1;
		repeat (8) begin
			fill_random();
			send_pixel(1'b0);
		end
		stall_mode = 0;

		// Filter 0 saturates, clips to zero, then lands in range
		fill_chosen(30000);
		send_pixel(1'b0);
		fill_chosen(-30000);
		send_pixel(1'b0);
		fill_chosen(100);
		send_pixel(1'b1);

		// Pixels beyond the layer length keep flowing after layer_done
		repeat (2) begin
			fill_random();
			send_pixel(1'b1);
		end
		@(posedge clk);
		in_valid <= 1'b0;

		while (out_count < TOTAL_PIXELS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		check_done(1'b1, layer_done);

		if (in_q.size() != 0) begin
			other_errs++;
			$display("%0d input values never reached an output vector", in_q.size());
		end
		if (!ready_dropped || !ready_recovered) begin
			other_errs++;
			$display("in_ready did not drop and recover under output stalls");
		end
		if (!seen_zero || !seen_sat || !seen_plain) begin
			other_errs++;
			$display("not every requantization outcome was produced");
		end

		$display("errors: %0d (value mismatches %0d, other failures %0d)",
			value_errs + other_errs, value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
rtl/conv_pkg.sv
rtl/kernel_rom.sv
rtl/ifm_streamer.sv
rtl/ifm_fifo.sv
rtl/pointwise_core.sv
rtl/squeeze_layer_top.sv
verification/squeeze_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module squeeze_layer_tb \
	-f all.f -Mdir obj_dir -o squeeze_layer_sim &&
./obj_dir/squeeze_layer_sim > sim.log 2>&1 ;
cat sim.log &&
! grep -q "tests failed" sim.log &&
grep -q "all tests passed" sim.log &&
echo "simulation passed" ||
{ echo "simulation FAILED"; exit 1; }
